//--- src/wave_pkg.sv
//**********************************************************************
// register map, waveform codes and level type for the waveform source
// all four registers are write-only, there is no readback path
// level is an unsigned gain, output = wave * level >>> 8
// so full scale is 255/256 and never exactly unity
//**********************************************************************

package wave_pkg;

	// command address
	typedef logic [1:0] cmd_addr_t;

	localparam cmd_addr_t ADDR_FREQ  = 2'd0;  // frequency word
	localparam cmd_addr_t ADDR_WAVE  = 2'd1;  // waveform select, data[1:0]
	localparam cmd_addr_t ADDR_LEVEL = 2'd2;  // output level, data[7:0]
	localparam cmd_addr_t ADDR_SYNC  = 2'd3;  // phase restart, data ignored

	// waveform select
	// encoding follows the low two data bits of an ADDR_WAVE write
	typedef enum logic [1:0] {
		WAVE_RAMP = 2'd0,
		WAVE_TRI  = 2'd1,
		WAVE_SQ   = 2'd2,
		WAVE_OFF  = 2'd3  // silence, reset value
	} wave_sel_e;

	// output gain
	typedef logic [7:0] level_t;

endpackage

//--- src/ramp_tri_sq.sv
//**********************************************************************
// phase accumulator with ramp, triangle and square outputs
// output rate = clk_i rate * freq_i / 2^RAMP_W while en_i is held high
// sync_i only takes effect on a clock where en_i is high
// triangle is one bit narrower than the ramp
// RAMP_W must be >= 3 and >= FREQ_W
//**********************************************************************

module ramp_tri_sq #(
	parameter int FREQ_W = 16,  // freq_i width
	parameter int RAMP_W = 16,  // phase and ramp width
	parameter int SGN_O  = 1    // 1 = two's complement ramp/tri, 0 = unsigned
) (
	input  logic              clk_i,
	input  logic              rst_i,   // async, active high
	input  logic              en_i,    // accumulate enable
	input  logic              sync_i,  // phase restart, needs en_i
	input  logic [FREQ_W-1:0] freq_i,  // phase increment
	output logic [RAMP_W-1:0] ramp_o,
	output logic [RAMP_W-2:0] tri_o,
	output logic              sq_o
);

	logic [RAMP_W-1:0] phase_q;  // unsigned phase
	logic [RAMP_W-2:0] tri_u;    // unsigned folded phase

	// accumulate, wraps mod 2^RAMP_W
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			phase_q <= '0;
		end else if (en_i) begin
			if (sync_i) begin
				phase_q <= '0;  // restart
			end else begin
				phase_q <= phase_q + RAMP_W'(freq_i);
			end
		end
	end

	// ramp straight from phase
	// MSB flip maps 0..2^N-1 onto -2^(N-1)..2^(N-1)-1
	always_comb begin
		if (SGN_O != 0) begin
			ramp_o = {~phase_q[RAMP_W-1], phase_q[RAMP_W-2:0]};
		end else begin
			ramp_o = phase_q;
		end
	end

	// fold lower bits on the second half of the cycle
	always_comb begin
		if (phase_q[RAMP_W-1]) begin
			tri_u = ~phase_q[RAMP_W-2:0];  // falling half
		end else begin
			tri_u = phase_q[RAMP_W-2:0];   // rising half
		end
	end

	always_comb begin
		if (SGN_O != 0) begin
			tri_o = {~tri_u[RAMP_W-2], tri_u[RAMP_W-3:0]};
		end else begin
			tri_o = tri_u;
		end
	end

	assign sq_o = phase_q[RAMP_W-1];  // always unsigned

	// freq word wider than the phase would lose its upper bits
	a_freq_fits: assert property (@(posedge clk_i) RAMP_W >= FREQ_W)
		else $error("ramp_tri_sq: FREQ_W exceeds RAMP_W");

endmodule

//--- src/wave_ctrl.sv
//**********************************************************************
// command intake, register file and accumulate-enable prescaler
// a write lands on the edge where cmd_valid_i and cmd_ready_o are high
// after an ADDR_SYNC write ready stays low until the next enable tick,
// which is 1 to DIV clocks
// FREQ_W must be >= 8 since level comes from data[7:0]
//**********************************************************************

module wave_ctrl
	import wave_pkg::*;
#(
	parameter int FREQ_W = 16,  // command data and frequency width
	parameter int DIV    = 4    // enable every DIV clocks, >= 1
) (
	input  logic              clk_i,
	input  logic              rst_i,        // async, active high
	input  logic              cmd_valid_i,
	input  cmd_addr_t         cmd_addr_i,
	input  logic [FREQ_W-1:0] cmd_data_i,
	output logic              cmd_ready_o,
	output logic              en_o,         // one clock in DIV
	output logic              sync_o,       // phase restart request
	output logic [FREQ_W-1:0] freq_o,
	output wave_sel_e         wave_sel_o,
	output level_t            level_o
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DIV - 1);

	typedef enum logic {
		IDLE,
		SYNC_WAIT  // sync requested, waiting for en tick
	} state_e;

	state_e           state_q;
	state_e           state_d;
	logic [CNT_W-1:0] div_cnt_q;
	logic             cmd_acc;  // handshake this clock

	// free-running prescaler, DIV = 1 keeps en_o high
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			div_cnt_q <= '0;
		end else if (div_cnt_q == CNT_MAX) begin
			div_cnt_q <= '0;
		end else begin
			div_cnt_q <= div_cnt_q + 1'b1;
		end
	end

	assign en_o = (div_cnt_q == CNT_MAX);

	assign cmd_ready_o = (state_q == IDLE);
	assign cmd_acc     = cmd_valid_i && cmd_ready_o;
	assign sync_o      = (state_q == SYNC_WAIT);  // held until consumed

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:      if (cmd_acc && cmd_addr_i == ADDR_SYNC) state_d = SYNC_WAIT;
			SYNC_WAIT: if (en_o) state_d = IDLE;  // accumulator took the sync
			default:   state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// register file
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			freq_o     <= '0;
			wave_sel_o <= WAVE_OFF;  // silent until told otherwise
			level_o    <= '0;
		end else if (cmd_acc) begin
			case (cmd_addr_i)
				ADDR_FREQ:  freq_o <= cmd_data_i;
				ADDR_WAVE:  wave_sel_o <= wave_sel_e'(cmd_data_i[1:0]);
				ADDR_LEVEL: level_o <= cmd_data_i[7:0];
				default:    ;  // sync has no data
			endcase
		end
	end

	// sync only rises after an accepted sync write
	a_sync_source: assert property (@(posedge clk_i) disable iff (rst_i)
		!sync_o |=> !sync_o || $past(cmd_acc && cmd_addr_i == ADDR_SYNC));

	// writes offered while stalled leave the registers alone
	a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(state_q == SYNC_WAIT && cmd_valid_i)
		|=> $stable(freq_o) && $stable(wave_sel_o) && $stable(level_o));

endmodule

//--- src/wave_shaper.sv
//**********************************************************************
// waveform select, alignment to the full signed range and level gain
// expects signed ramp/tri from the accumulator (SGN_O = 1)
// sample_o updates one clock after each en_i clock and then holds,
// sample_valid_o pulses with it, there is no back-pressure
//**********************************************************************

module wave_shaper
	import wave_pkg::*;
#(
	parameter int RAMP_W = 16  // sample width
) (
	input  logic                     clk_i,
	input  logic                     rst_i,          // async, active high
	input  logic                     en_i,           // accumulator enable
	input  wave_sel_e                wave_sel_i,
	input  level_t                   level_i,
	input  logic        [RAMP_W-1:0] ramp_i,
	input  logic        [RAMP_W-2:0] tri_i,
	input  logic                     sq_i,
	output logic signed [RAMP_W-1:0] sample_o,
	output logic                     sample_valid_o
);

	logic signed [RAMP_W-1:0] wave_al;  // aligned, full scale
	logic signed [RAMP_W+8:0] prod;     // wave * level
	logic signed [RAMP_W+8:0] prod_sh;  // after /256
	logic                     en_d;     // phase settled this clock

	// align every shape to +-2^(RAMP_W-1)
	always_comb begin
		case (wave_sel_i)
			WAVE_RAMP: wave_al = $signed(ramp_i);
			WAVE_TRI:  wave_al = $signed({tri_i, 1'b0});  // one bit narrower
			WAVE_SQ: begin
				if (sq_i) begin
					wave_al = $signed({1'b0, {(RAMP_W-1){1'b1}}});  // most positive
				end else begin
					wave_al = $signed({1'b1, {(RAMP_W-1){1'b0}}});  // most negative
				end
			end
			default:   wave_al = '0;  // off
		endcase
	end

	// level is unsigned, zero-extend before the signed multiply
	assign prod    = wave_al * $signed({1'b0, level_i});
	assign prod_sh = prod >>> 8;

	// phase register moves on the en_i edge, sample it one clock later
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			en_d <= 1'b0;
		end else begin
			en_d <= en_i;
		end
	end

	// sample held between strobes, the modulator reads it every clock
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			sample_o       <= '0;
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= en_d;
			if (en_d) begin
				sample_o <= prod_sh[RAMP_W-1:0];  // fits, |level| < 256
			end
		end
	end

	// a nonzero gain never flips the sign of the wave
	a_gain_sign: assert property (@(posedge clk_i) disable iff (rst_i)
		(en_d && level_i != '0) |=> (sample_o[RAMP_W-1] == $past(wave_al[RAMP_W-1])));

endmodule

//--- src/sd_dac.sv
//**********************************************************************
// first-order sigma-delta modulator, signed sample to 1-bit stream
// runs every clock on the held sample, dac_o lags by one register
// over 2^RAMP_W clocks the ones count is the offset-binary sample +-1
// most negative input gives a steady zero, no full-scale one exists
//**********************************************************************

module sd_dac #(
	parameter int RAMP_W = 16  // sample width
) (
	input  logic                     clk_i,
	input  logic                     rst_i,     // async, active high
	input  logic signed [RAMP_W-1:0] sample_i,
	output logic                     dac_o      // needs an RC filter
);

	logic [RAMP_W-1:0] offs;   // offset binary
	logic [RAMP_W:0]   sum;    // carry in top bit
	logic [RAMP_W:0]   acc_q;  // carry + remainder

	// flip MSB, 0 maps to mid scale
	assign offs = {~sample_i[RAMP_W-1], sample_i[RAMP_W-2:0]};

	// carry is dropped before adding, only the remainder accumulates
	assign sum = {1'b0, acc_q[RAMP_W-1:0]} + {1'b0, offs};

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			acc_q <= '0;  // error starts at zero
		end else begin
			acc_q <= sum;
		end
	end

	assign dac_o = acc_q[RAMP_W];  // registered overflow

	// overflow needs the remainder to have wrapped, so no two carries
	// in a row unless the input is above mid scale
	a_density: assert property (@(posedge clk_i) disable iff (rst_i)
		(dac_o && !offs[RAMP_W-1] && $stable(offs)) |=> !dac_o);

endmodule

//--- src/wave_gen_top.sv
//**********************************************************************
// waveform source top level
// command port is valid/ready, sample output is a free strobe
// FREQ_W >= 8, RAMP_W >= 4 and >= FREQ_W, DIV >= 1
// accumulator is fixed to signed outputs for the gain stage
//**********************************************************************

module wave_gen_top
	import wave_pkg::*;
#(
	parameter int FREQ_W = 16,  // frequency word and command data width
	parameter int RAMP_W = 16,  // phase and sample width
	parameter int DIV    = 4    // sample rate = clk / DIV
) (
	input  logic                     clk_i,
	input  logic                     rst_i,           // async, active high
	input  logic                     cmd_valid_i,
	input  cmd_addr_t                cmd_addr_i,
	input  logic        [FREQ_W-1:0] cmd_data_i,
	output logic                     cmd_ready_o,     // low during sync wait
	output logic signed [RAMP_W-1:0] sample_o,
	output logic                     sample_valid_o,  // one clock per sample
	output logic                     dac_o            // 1-bit stream
);

	logic              en;
	logic              sync;
	logic [FREQ_W-1:0] freq;
	wave_sel_e         wave_sel;
	level_t            level;
	logic [RAMP_W-1:0] ramp;
	logic [RAMP_W-2:0] tri_wave;
	logic              sq;

	wave_ctrl #(.FREQ_W(FREQ_W), .DIV(DIV)) u_wave_ctrl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_addr_i  (cmd_addr_i),
		.cmd_data_i  (cmd_data_i),
		.cmd_ready_o (cmd_ready_o),
		.en_o        (en),
		.sync_o      (sync),
		.freq_o      (freq),
		.wave_sel_o  (wave_sel),
		.level_o     (level)
	);

	ramp_tri_sq #(.FREQ_W(FREQ_W), .RAMP_W(RAMP_W), .SGN_O(1)) u_ramp_tri_sq (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.en_i   (en),
		.sync_i (sync),
		.freq_i (freq),
		.ramp_o (ramp),
		.tri_o  (tri_wave),
		.sq_o   (sq)
	);

	wave_shaper #(.RAMP_W(RAMP_W)) u_wave_shaper (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.en_i           (en),
		.wave_sel_i     (wave_sel),
		.level_i        (level),
		.ramp_i         (ramp),
		.tri_i          (tri_wave),
		.sq_i           (sq),
		.sample_o       (sample_o),
		.sample_valid_o (sample_valid_o)
	);

	// modulator reads the held sample, not the strobe
	sd_dac #(.RAMP_W(RAMP_W)) u_sd_dac (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.sample_i (sample_o),
		.dac_o    (dac_o)
	);

endmodule

//--- testbench/tb_wave_gen.sv
//**********************************************************************
// directed testbench for the waveform source top level
// 8-bit phase and samples, DIV = 4, so a full modulator window is 256
// stimulus on the rising edge, outputs sampled on the falling edge
// random frequency words and levels come from an LCG with a fixed seed
//**********************************************************************

module tb_wave_gen
	import wave_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FREQ_W     = 8;
	localparam int RAMP_W     = 8;
	localparam int DIV        = 4;
	localparam int CLK_PERIOD = 8;
	localparam int HALF       = 1 << (RAMP_W - 1);  // half scale
	localparam int N_LEVELS   = 5;                   // density runs
	// samples taken by all tests, density runs count their window too
	localparam int SAMPLES_TOTAL   = 8 + 64 + 3 * 32 + 10 + N_LEVELS * (256 / DIV + 4);
	localparam int WATCHDOG_CYCLES = SAMPLES_TOTAL * DIV + 2000;  // writes and stalls

	logic                     clk_i;
	logic                     rst_i;
	logic                     cmd_valid_i;
	cmd_addr_t                cmd_addr_i;
	logic        [FREQ_W-1:0] cmd_data_i;
	logic                     cmd_ready_o;
	logic signed [RAMP_W-1:0] sample_o;
	logic                     sample_valid_o;
	logic                     dac_o;

	logic [31:0] lcg_state = 32'hda0bfd61;
	int          last_wait;     // stall cycles of the last write
	int          test_errors;
	int          check_errors;
	int          tests_run;
	int          tests_failed;

	wave_gen_top #(.FREQ_W(FREQ_W), .RAMP_W(RAMP_W), .DIV(DIV)) u_wave_gen_top (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cmd_valid_i    (cmd_valid_i),
		.cmd_addr_i     (cmd_addr_i),
		.cmd_data_i     (cmd_data_i),
		.cmd_ready_o    (cmd_ready_o),
		.sample_o       (sample_o),
		.sample_valid_o (sample_valid_o),
		.dac_o          (dac_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// hard stop if a handshake or strobe never comes
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: no progress after %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];  // top bits, best period
	endfunction

	// reference model straight from the waveform rules
	function automatic int expected_sample(input wave_sel_e sel, input int phase,
	                                       input int level);
		int fold;
		int wave;
		fold = 0;
		case (sel)
			WAVE_RAMP: wave = phase - HALF;  // signed ramp
			WAVE_TRI: begin
				fold = (phase < HALF) ? phase : (2 * HALF - 1 - phase);  // fold upper half
				wave = 2 * fold - HALF;  // rescaled to full range
			end
			WAVE_SQ:   wave = (phase < HALF) ? -HALF : HALF - 1;
			default:   wave = 0;
		endcase
		return (wave * level) >>> 8;  // gain, floor division
	endfunction

	task automatic check_val(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			test_errors++;
			check_errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// hold the write until the edge that sees ready high
	task automatic write_reg(input cmd_addr_t addr, input logic [FREQ_W-1:0] data);
		last_wait = 0;
		@(posedge clk_i);
		cmd_valid_i <= 1'b1;
		cmd_addr_i  <= addr;
		cmd_data_i  <= data;
		@(negedge clk_i);
		while (!cmd_ready_o) begin
			last_wait++;
			@(negedge clk_i);
		end
		@(posedge clk_i);  // accepted here
		cmd_valid_i <= 1'b0;
	endtask

	task automatic wait_ready();
		@(negedge clk_i);
		while (!cmd_ready_o) @(negedge clk_i);
	endtask

	task automatic next_sample(output logic signed [RAMP_W-1:0] s);
		@(negedge clk_i);
		while (!sample_valid_o) @(negedge clk_i);
		s = sample_o;
	endtask

	// program a wave, restart the phase and compare count samples
	task automatic run_wave(input string name, input wave_sel_e sel,
	                        input logic [7:0] freq, input logic [7:0] level, input int count);
		logic signed [RAMP_W-1:0] s;
		int                       n;
		int                       phase;
		write_reg(ADDR_FREQ, freq);
		write_reg(ADDR_WAVE, 8'(sel));
		write_reg(ADDR_LEVEL, level);
		write_reg(ADDR_SYNC, 8'h00);
		wait_ready();  // sync has reached the accumulator
		for (n = 0; n < count; n++) begin
			next_sample(s);
			phase = (n * int'(freq)) % (1 << RAMP_W);  // n-th after sync
			check_val(name, expected_sample(sel, phase, int'(level)), int'(s));
		end
	endtask

	task automatic reset_state();
		logic signed [RAMP_W-1:0] s;
		int                       n;
		@(negedge clk_i);
		check_val("reset ready", 1, int'(cmd_ready_o));
		check_val("reset valid", 0, int'(sample_valid_o));
		check_val("reset dac", 0, int'(dac_o));
		write_reg(ADDR_FREQ, 8'h11);   // phase keeps moving
		write_reg(ADDR_LEVEL, 8'hff);  // full gain, wave left at reset
		for (n = 0; n < 8; n++) begin
			next_sample(s);
			check_val("reset silence", 0, int'(s));  // WAVE_OFF
		end
		report_test("reset");
	endtask

	task automatic ramp_wave();
		run_wave("ramp", WAVE_RAMP, lcg_byte(), 8'hff, 64);
		report_test("ramp");
	endtask

	task automatic tri_square_waves();
		run_wave("triangle", WAVE_TRI, lcg_byte(), lcg_byte(), 32);
		run_wave("square", WAVE_SQ, lcg_byte(), lcg_byte(), 32);
		run_wave("square level 0", WAVE_SQ, lcg_byte(), 8'h00, 32);  // all zero
		report_test("triangle and square");
	endtask

	task automatic sync_stall();
		logic signed [RAMP_W-1:0] s;
		logic        [7:0]        f2;
		int                       n;
		f2 = lcg_byte() | 8'h01;  // nonzero so the restart shows
		write_reg(ADDR_FREQ, lcg_byte());
		write_reg(ADDR_WAVE, 8'(WAVE_RAMP));
		write_reg(ADDR_LEVEL, 8'hff);
		next_sample(s);    // strobe gives the prescaler position
		@(negedge clk_i);  // sync write then lands on an enable tick
		write_reg(ADDR_SYNC, 8'h00);
		@(negedge clk_i);
		if (cmd_ready_o !== 1'b0) begin
			$display("sync stall: cmd_ready_o stayed high after a sync write");
			test_errors++;
			check_errors++;
		end
		write_reg(ADDR_FREQ, f2);  // offered while stalled
		if (last_wait < 1 || last_wait > DIV) begin
			$display("sync stall: write held %0d cycles, outside 1 to %0d", last_wait, DIV);
			test_errors++;
			check_errors++;
		end
		for (n = 0; n < 8; n++) begin
			next_sample(s);
			check_val("sync stall", expected_sample(WAVE_RAMP, (n * int'(f2)) % 256, 255),
			          int'(s));
		end
		report_test("sync stall");
	endtask

	task automatic dac_density();
		logic signed [RAMP_W-1:0] s;
		logic        [7:0]        levels [N_LEVELS];
		int                       i;
		int                       ones;
		int                       offset;
		levels[0] = 8'h00;  // mid scale
		levels[1] = 8'hff;  // near bottom
		levels[2] = 8'h80;
		levels[3] = lcg_byte();
		levels[4] = lcg_byte();
		for (i = 0; i < N_LEVELS; i++) begin
			write_reg(ADDR_FREQ, 8'h00);  // phase parks at 0
			write_reg(ADDR_WAVE, 8'(WAVE_SQ));
			write_reg(ADDR_LEVEL, levels[i]);
			write_reg(ADDR_SYNC, 8'h00);
			wait_ready();
			next_sample(s);
			offset = expected_sample(WAVE_SQ, 0, int'(levels[i]));
			check_val("density sample", offset, int'(s));
			offset = offset + HALF;  // offset binary
			repeat (2) @(negedge clk_i);  // modulator sees the new sample
			ones = 0;
			repeat (256) begin
				@(negedge clk_i);
				ones = ones + int'(dac_o);
			end
			if (ones < offset - 1 || ones > offset + 1) begin
				$display("CHECK FAILED density: expected %0d, actual %0d", offset, ones);
				test_errors++;
				check_errors++;
			end
		end
		report_test("density");
	endtask

	initial begin
		rst_i        = 1'b1;
		cmd_valid_i  = 1'b0;
		cmd_addr_i   = ADDR_FREQ;
		cmd_data_i   = '0;
		last_wait    = 0;
		test_errors  = 0;
		check_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		reset_state();
		ramp_wave();
		tri_square_waves();
		sync_stall();
		dac_density();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
		         tests_run, tests_failed, check_errors);
		if (check_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
src/wave_pkg.sv
src/ramp_tri_sq.sv
src/wave_ctrl.sv
src/wave_shaper.sv
src/sd_dac.sv
src/wave_gen_top.sv
testbench/tb_wave_gen.sv

//--- Makefile
# Verilator build and run of the waveform source testbench

SIM  := obj_dir/Vtb_wave_gen
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wave_gen -f project.f

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
